// File: source/dcache_pkg.sv
package dcache_pkg;

  // address split: tag | index | offset
  localparam int ADDR_W   = 20;  // byte address
  localparam int WORD_W   = 32;  // one word per line
  localparam int INDEX_W  = 8;   // 256 sets
  localparam int TAG_W    = 10;  // upper address bits
  localparam int OFFSET_W = 2;   // byte within word
  localparam int NUM_WAYS = 4;   // ages form a 4-way permutation

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [1:0]          way_t;   // way number
  typedef logic [1:0]          age_t;   // 0 = most recent, 3 = lru

  // bytes of one word
  typedef logic [WORD_W/8-1:0] byte_mask_t;

  // store width, encoding as on the cpu side
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10,
    SIZE_BAD  = 2'b11  // illegal, writes nothing
  } store_size_t;

  // control fsm
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,  // waiting for request
    ST_LOOKUP = 2'b01,  // tag compare, hit answers here
    ST_REFILL = 2'b10   // miss, waiting for refill word
  } state_t;

endpackage

// File: source/dcache_decode.sv
`timescale 1ns/1ps

module dcache_decode (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic                    req_valid,
  input  logic                    req_write,
  input  dcache_pkg::addr_t       req_addr,
  input  dcache_pkg::store_size_t req_size,
  input  dcache_pkg::word_t       req_wdata,
  input  logic                    refill_valid,
  input  logic                    hit,
  output logic                    req_ready,
  output logic                    resp_valid,
  output logic                    refill_req,
  output dcache_pkg::addr_t       refill_addr,
  output dcache_pkg::index_t      cur_index,
  output dcache_pkg::tag_t        cur_tag,
  output dcache_pkg::offset_t     cur_offset,
  output logic                    cur_write,
  output dcache_pkg::store_size_t cur_size,
  output dcache_pkg::word_t       cur_wdata,
  output logic                    access_en,
  output logic                    fill,
  output logic                    data_we
);

  dcache_pkg::state_t state, next_state;
  logic               out_of_reset;  // low in the reset-exit idle cycle
  logic               accept;        // request taken this edge
  logic               lookup_hit;

  assign accept     = req_valid && req_ready;
  assign lookup_hit = (state == dcache_pkg::ST_LOOKUP) && hit;

  // fsm and reset-exit flag
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state        <= dcache_pkg::ST_IDLE;
      out_of_reset <= 1'b0;
    end else begin
      state        <= next_state;
      out_of_reset <= 1'b1;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      dcache_pkg::ST_IDLE:   if (accept) next_state = dcache_pkg::ST_LOOKUP;
      dcache_pkg::ST_LOOKUP: next_state = hit ? dcache_pkg::ST_IDLE : dcache_pkg::ST_REFILL;
      dcache_pkg::ST_REFILL: if (refill_valid) next_state = dcache_pkg::ST_IDLE;
      default:               next_state = dcache_pkg::ST_IDLE;
    endcase
  end

  // request capture, address split into fields
  always_ff @(posedge CLK) begin
    if (accept) begin
      cur_offset <= req_addr[dcache_pkg::OFFSET_W-1:0];
      cur_index  <= req_addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
      cur_tag    <= req_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
      cur_write  <= req_write;
      cur_size   <= req_write ? req_size : dcache_pkg::SIZE_BAD;  // reads merge nothing
      cur_wdata  <= req_wdata;
    end
  end

  assign req_ready   = (state == dcache_pkg::ST_IDLE) && out_of_reset;
  assign refill_req  = (state == dcache_pkg::ST_REFILL);
  assign refill_addr = {cur_tag, cur_index, {dcache_pkg::OFFSET_W{1'b0}}};  // word aligned

  assign fill       = refill_req && refill_valid;  // refill_valid ignored elsewhere
  assign resp_valid = lookup_hit || fill;          // one per request, stores too
  assign access_en  = lookup_hit || fill;          // ages move on hit or fill
  // store hit with a legal size, or any fill (bad-size store fills unmerged)
  assign data_we    = (lookup_hit && cur_write && (cur_size != dcache_pkg::SIZE_BAD)) || fill;

  // requester holds its request until taken
  a_req_hold: assert property (@(posedge CLK) disable iff (!resetn)
    req_valid && !req_ready |=> req_valid && $stable(req_addr));

  // refill request and address held until the word comes back
  a_refill_hold: assert property (@(posedge CLK) disable iff (!resetn)
    refill_req && !refill_valid |=> refill_req && $stable(refill_addr));

endmodule

// File: source/dcache_tag_lru.sv
`timescale 1ns/1ps

module dcache_tag_lru (
  input  logic               CLK,
  input  logic               resetn,
  input  dcache_pkg::index_t cur_index,
  input  dcache_pkg::tag_t   cur_tag,
  input  logic               access_en,
  input  logic               fill,
  output logic               hit,
  output dcache_pkg::way_t   sel_way
);

  localparam int NUM_SETS = 1 << dcache_pkg::INDEX_W;
  localparam int NUM_WAYS = dcache_pkg::NUM_WAYS;

  dcache_pkg::tag_t    tag_mem   [NUM_WAYS][NUM_SETS];  // tag of each way and set
  logic [NUM_WAYS-1:0] valid_mem [NUM_SETS];
  dcache_pkg::age_t    age_mem   [NUM_SETS][NUM_WAYS];

  dcache_pkg::age_t    cur_age [NUM_WAYS];  // ages of the addressed set
  logic [NUM_WAYS-1:0] cur_valid;
  dcache_pkg::way_t    hit_way;
  dcache_pkg::way_t    lru_way;             // way with age 3
  dcache_pkg::way_t    free_way;            // lowest invalid way
  logic                any_free;
  dcache_pkg::age_t    sel_age;
  logic [NUM_WAYS-1:0] age_seen;            // one bit per age value
  logic                ages_ok;

  assign cur_valid = valid_mem[cur_index];

  always_comb begin
    hit      = 1'b0;
    hit_way  = '0;
    lru_way  = '0;
    free_way = '0;
    any_free = 1'b0;
    age_seen = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      cur_age[w] = age_mem[cur_index][w];
      age_seen[cur_age[w]] = 1'b1;
      if (cur_valid[w] && (tag_mem[w][cur_index] == cur_tag)) begin
        hit     = 1'b1;               // at most one way matches
        hit_way = dcache_pkg::way_t'(w);
      end
      if (cur_age[w] == dcache_pkg::age_t'(NUM_WAYS - 1))
        lru_way = dcache_pkg::way_t'(w);
    end
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin  // descending, lowest wins
      if (!cur_valid[w]) begin
        free_way = dcache_pkg::way_t'(w);
        any_free = 1'b1;
      end
    end
  end

  // no hit during refill, so this is the victim there
  assign sel_way = hit ? hit_way : (any_free ? free_way : lru_way);
  assign sel_age = cur_age[sel_way];
  assign ages_ok = &age_seen;  // all four ages present

  // tags written on fill only
  always_ff @(posedge CLK) begin
    if (access_en && fill)
      tag_mem[sel_way][cur_index] <= cur_tag;
  end

  // valid bits and ages
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_mem[s] <= '0;
        for (int w = 0; w < NUM_WAYS; w++)
          age_mem[s][w] <= dcache_pkg::age_t'(w);  // start as a permutation
      end
    end else if (access_en) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (dcache_pkg::way_t'(w) == sel_way)
          age_mem[cur_index][w] <= '0;                   // accessed way is newest
        else if (cur_age[w] < sel_age)
          age_mem[cur_index][w] <= cur_age[w] + 1'b1;    // younger ones age
      end
      if (fill)
        valid_mem[cur_index][sel_way] <= 1'b1;
    end
  end

  // set index holds through the idle cycle after an access
  a_age_perm: assert property (@(posedge CLK) disable iff (!resetn)
    access_en |=> ages_ok);

endmodule

// File: source/dcache_data_store.sv
`timescale 1ns/1ps

module dcache_data_store (
  input  logic                    CLK,
  input  dcache_pkg::index_t      cur_index,
  input  dcache_pkg::way_t        sel_way,
  input  dcache_pkg::offset_t     cur_offset,
  input  dcache_pkg::store_size_t cur_size,
  input  dcache_pkg::word_t       cur_wdata,
  input  logic                    data_we,
  input  logic                    fill,
  input  dcache_pkg::word_t       refill_data,
  output dcache_pkg::word_t       resp_rdata
);

  localparam int NUM_SETS  = 1 << dcache_pkg::INDEX_W;
  localparam int NUM_BYTES = dcache_pkg::WORD_W / 8;

  dcache_pkg::word_t      data_mem [dcache_pkg::NUM_WAYS][NUM_SETS];
  dcache_pkg::word_t      stored;   // word of the selected way
  dcache_pkg::word_t      base;     // word the store merges into
  dcache_pkg::word_t      merged;
  dcache_pkg::byte_mask_t mask;

  // byte lanes from size and offset
  always_comb begin
    case (cur_size)
      dcache_pkg::SIZE_BYTE: mask = dcache_pkg::byte_mask_t'(1) << cur_offset;
      dcache_pkg::SIZE_HALF: mask = cur_offset[1] ? 4'b1100 : 4'b0011;  // upper or lower half
      dcache_pkg::SIZE_WORD: mask = 4'b1111;
      default:               mask = 4'b0000;  // SIZE_BAD, reads
    endcase
  end

  assign stored = data_mem[sel_way][cur_index];
  assign base   = fill ? refill_data : stored;  // write-allocate merges into refill

  // store data arrives already placed in its lanes
  always_comb begin
    for (int b = 0; b < NUM_BYTES; b++)
      merged[8*b +: 8] = mask[b] ? cur_wdata[8*b +: 8] : base[8*b +: 8];
  end

  always_ff @(posedge CLK) begin
    if (data_we)
      data_mem[sel_way][cur_index] <= merged;
  end

  // refill word bypasses the array on a miss
  assign resp_rdata = fill ? refill_data : stored;

  // decode only writes without lanes when filling
  a_mask_nonempty: assert property (@(posedge CLK)
    data_we && !fill |-> mask != '0);

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   req_valid,
  input  logic                   req_write,
  input  dcache_pkg::addr_t       req_addr,
  input  dcache_pkg::store_size_t req_size,
  input  dcache_pkg::word_t       req_wdata,
  output logic                   req_ready,
  output logic                   resp_valid,
  output dcache_pkg::word_t       resp_rdata,
  output logic                   refill_req,
  output dcache_pkg::addr_t       refill_addr,
  input  logic                   refill_valid,
  input  dcache_pkg::word_t       refill_data
);

  dcache_pkg::index_t      cur_index;   // set of the current request
  dcache_pkg::tag_t        cur_tag;
  dcache_pkg::offset_t     cur_offset;
  dcache_pkg::store_size_t cur_size;    // SIZE_BAD for reads
  dcache_pkg::word_t       cur_wdata;
  logic                    access_en;   // hit in lookup or fill
  logic                    fill;        // refill word arrives
  logic                    data_we;     // data array write
  logic                    hit;
  dcache_pkg::way_t        sel_way;     // hit way or victim

  dcache_decode u_decode (
    .CLK          (CLK),
    .resetn       (resetn),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_size     (req_size),
    .req_wdata    (req_wdata),
    .refill_valid (refill_valid),
    .hit          (hit),
    .req_ready    (req_ready),
    .resp_valid   (resp_valid),
    .refill_req   (refill_req),
    .refill_addr  (refill_addr),
    .cur_index    (cur_index),
    .cur_tag      (cur_tag),
    .cur_offset   (cur_offset),
    .cur_write    (),               // stores reach the data path through cur_size
    .cur_size     (cur_size),
    .cur_wdata    (cur_wdata),
    .access_en    (access_en),
    .fill         (fill),
    .data_we      (data_we)
  );

  dcache_tag_lru u_tag_lru (
    .CLK       (CLK),
    .resetn    (resetn),
    .cur_index (cur_index),
    .cur_tag   (cur_tag),
    .access_en (access_en),
    .fill      (fill),
    .hit       (hit),
    .sel_way   (sel_way)
  );

  dcache_data_store u_data_store (
    .CLK         (CLK),
    .cur_index   (cur_index),
    .sel_way     (sel_way),
    .cur_offset  (cur_offset),
    .cur_size    (cur_size),
    .cur_wdata   (cur_wdata),
    .data_we     (data_we),
    .fill        (fill),
    .refill_data (refill_data),
    .resp_rdata  (resp_rdata)
  );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic resetn
);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;  // 40 ns period
  end

  initial begin
    resetn = 1'b0;
    repeat (10) @(posedge CLK);  // 10 cycles in reset
    #2 resetn = 1'b1;            // released like any other input
  end

endmodule

// File: tests/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic                    req_valid,
  input  logic                    req_write,
  input  dcache_pkg::addr_t       req_addr,
  input  dcache_pkg::store_size_t req_size,
  input  dcache_pkg::word_t       req_wdata,
  input  logic                    req_ready,
  input  logic                    resp_valid,
  input  dcache_pkg::word_t       resp_rdata,
  input  logic                    refill_req,
  input  dcache_pkg::addr_t       refill_addr,
  input  logic                    refill_valid,
  input  dcache_pkg::word_t       refill_data,
  input  int                      test_num,
  output int                      checks,
  output int                      errors
);

  dcache_pkg::tag_t        m_tag   [4][256];  // reference cache
  logic                    m_valid [4][256];
  dcache_pkg::age_t        m_age   [4][256];
  dcache_pkg::word_t       m_data  [4][256];
  int                      phase;             // 0 idle, 1 lookup, 2 refill
  int                      since_reset, last_test, test_checks, test_errs;
  logic                    p_write, p_hit, found;
  dcache_pkg::addr_t       p_addr;            // request in flight
  dcache_pkg::store_size_t p_size;
  dcache_pkg::word_t       p_wdata;
  dcache_pkg::way_t        p_way;
  dcache_pkg::index_t      idx;

  function automatic string test_name(int n);
    case (n)
      1: return "reset";
      2: return "cold_reads";
      3: return "store_sizes";
      4: return "replacement";
      5: return "random_mix";
      default: return "none";
    endcase
  endfunction

  task automatic check(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    test_checks++;
    if (exp !== act) begin
      errors++;
      test_errs++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name(test_num), what, exp, act);
    end
  endtask

  // lane b written if size covers it at this offset
  function automatic dcache_pkg::word_t merge(dcache_pkg::word_t base, dcache_pkg::word_t wd,
                                              dcache_pkg::store_size_t sz, logic [1:0] off);
    dcache_pkg::word_t r;
    r = base;
    for (int b = 0; b < 4; b++) begin
      if ((sz == dcache_pkg::SIZE_WORD) || (sz == dcache_pkg::SIZE_BYTE && b == int'(off))
          || (sz == dcache_pkg::SIZE_HALF && b / 2 == int'(off[1])))
        r[8*b +: 8] = wd[8*b +: 8];
    end
    return r;
  endfunction

  // accessed way becomes newest, younger ways age by one
  task automatic touch(dcache_pkg::index_t i, dcache_pkg::way_t way);
    dcache_pkg::age_t a;
    a = m_age[way][i];
    for (int w = 0; w < 4; w++) begin
      if (w == int'(way)) m_age[w][i] = 2'd0;
      else if (m_age[w][i] < a) m_age[w][i] = m_age[w][i] + 2'd1;
    end
  endtask

  // sampled mid-cycle, inputs and outputs settled
  always @(negedge CLK) begin
    if (!resetn) begin
      for (int s = 0; s < 256; s++) begin
        for (int w = 0; w < 4; w++) begin
          m_valid[w][s] = 1'b0;
          m_age[w][s]   = 2'(w);  // ages start as way number
        end
      end
      phase = 0;
      since_reset = 0;
      checks = 0;
      errors = 0;
      test_checks = 0;
      test_errs = 0;
      last_test = test_num;
    end else begin
      if (test_num != last_test) begin  // previous test finished
        $display("test %0d %s: %s, %0d checks, %0d mismatches", last_test, test_name(last_test),
                 (test_errs == 0) ? "ok" : "FAILED", test_checks, test_errs);
        last_test = test_num;
        test_checks = 0;
        test_errs = 0;
      end
      since_reset++;
      if (since_reset == 1) begin  // reset-exit idle cycle
        check("req_ready in reset-exit cycle", 0, 32'(req_ready));
        check("resp_valid after reset", 0, 32'(resp_valid));
        check("refill_req after reset", 0, 32'(refill_req));
      end
      if (since_reset == 2) check("req_ready after reset exit", 1, 32'(req_ready));
      case (phase)
        0: begin
          if (resp_valid || refill_req) begin
            errors++;
            test_errs++;
            $display("%s: response or refill request with no request outstanding",
                     test_name(test_num));
          end
          if (req_valid && req_ready) begin  // taken at the coming edge
            p_write = req_write;
            p_addr  = req_addr;
            p_size  = req_size;
            p_wdata = req_wdata;
            idx     = req_addr[9:2];
            p_hit   = 1'b0;
            for (int w = 0; w < 4; w++) begin
              if (m_valid[w][idx] && m_tag[w][idx] == req_addr[19:10]) begin
                p_hit = 1'b1;
                p_way = 2'(w);
              end
            end
            phase = 1;
          end
        end
        1: begin
          check("req_ready in lookup", 0, 32'(req_ready));  // busy
          check("hit", 32'(p_hit), 32'(resp_valid));  // hit answers in lookup
          if (p_hit) begin
            if (!p_write) check("read data", m_data[p_way][idx], resp_rdata);
            else m_data[p_way][idx] = merge(m_data[p_way][idx], p_wdata, p_size, p_addr[1:0]);
            touch(idx, p_way);
            phase = 0;
          end else begin
            phase = 2;
          end
        end
        default: begin
          check("req_ready in refill", 0, 32'(req_ready));
          check("refill_addr", 32'({p_addr[19:2], 2'b00}), 32'(refill_addr));
          check("resp_valid in refill", 32'(refill_valid), 32'(resp_valid));  // only with refill
          if (!refill_req) begin
            errors++;
            test_errs++;
            $display("%s: refill request missing after a miss", test_name(test_num));
            phase = 0;  // resync on next request
          end else if (refill_valid) begin
            if (!p_write) check("read data", refill_data, resp_rdata);
            found = 1'b0;
            for (int w = 0; w < 4; w++) begin  // first free way
              if (!found && !m_valid[w][idx]) begin
                p_way = 2'(w);
                found = 1'b1;
              end
            end
            if (!found) begin  // else oldest
              for (int w = 0; w < 4; w++)
                if (m_age[w][idx] == 2'd3) p_way = 2'(w);
            end
            m_tag[p_way][idx]   = p_addr[19:10];
            m_valid[p_way][idx] = 1'b1;
            m_data[p_way][idx]  = p_write ? merge(refill_data, p_wdata, p_size, p_addr[1:0])
                                          : refill_data;  // evicted store simply lost
            touch(idx, p_way);
            phase = 0;
          end
        end
      endcase
    end
  end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

  logic                    CLK, resetn;
  logic                    req_valid, req_write, req_ready, resp_valid;
  dcache_pkg::addr_t       req_addr, refill_addr;
  dcache_pkg::store_size_t req_size;
  dcache_pkg::word_t       req_wdata, resp_rdata, refill_data;
  logic                    refill_req, refill_valid;
  int                      test_num, checks, errors;
  int                      seed, delay_seed, delay_left, n;
  logic                    hung;  // some wait ran out
  dcache_pkg::addr_t       a;

  tb_clock u_clk (.*);
  dcache_top u_dut (.*);
  tb_checker u_chk (.*);

  function automatic int rnd(int lim);
    return ($random(seed) & 32'h7fff_ffff) % lim;
  endfunction

  function automatic dcache_pkg::addr_t make_addr(int tag, int index);
    return {10'(tag), 8'(index), 2'(rnd(4))};  // random byte offset
  endfunction

  // one request, held until taken, then wait for its response
  task automatic access(input logic wr, input dcache_pkg::addr_t addr,
                        input dcache_pkg::store_size_t sz, input dcache_pkg::word_t wd);
    int cnt;
    if (hung) return;
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_size  = sz;
    req_wdata = wd;
    cnt = 0;
    do begin
      @(negedge CLK);
      cnt++;
    end while (!req_ready && cnt < 200);
    if (!req_ready) begin
      $display("timeout: req_ready stayed low for 200 cycles");
      hung = 1'b1;
      return;
    end
    @(posedge CLK);  // accepted here
    #2;
    req_valid = 1'b0;
    cnt = 0;
    do begin
      @(negedge CLK);
      cnt++;
    end while (!resp_valid && cnt < 200);
    if (!resp_valid) begin
      $display("timeout: no response within 200 cycles of acceptance");
      hung = 1'b1;
      return;
    end
    @(posedge CLK);
    #2;
  endtask

  // refill responder, 0 to 4 cycles late
  initial begin
    delay_seed   = 32'hb2e2_15a0;
    refill_valid = 1'b0;
    refill_data  = '0;
    delay_left   = 0;
    forever begin
      @(posedge CLK);
      #2;
      if (refill_valid) begin
        refill_valid = 1'b0;  // one-cycle pulse
        delay_left   = ($random(delay_seed) & 32'h7fff_ffff) % 5;
      end else if (refill_req) begin
        if (delay_left == 0) begin
          refill_valid = 1'b1;
          refill_data  = ({12'h000, refill_addr} ^ 32'h5a5a_0000) + 32'(refill_addr[9:2]);
        end else begin
          delay_left--;
        end
      end
    end
  end

  initial begin
    seed      = 32'hb2e2_15a0;
    hung      = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_size  = dcache_pkg::SIZE_WORD;
    req_wdata = '0;
    test_num  = 1;  // reset, checked by u_chk
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (!resetn && n < 200);
    if (!resetn) begin
      $display("timeout: reset never released");
      hung = 1'b1;
    end
    repeat (3) @(posedge CLK);
    #2;
    test_num = 2;  // few lines, repeats hit
    for (int i = 0; i < 40; i++)
      access(1'b0, make_addr(3 + rnd(2), 16 + rnd(3)), dcache_pkg::SIZE_WORD, '0);
    test_num = 3;  // every size, hit then miss
    for (int i = 0; i < 16; i++) begin
      a = make_addr(rnd(4), 64 + i);
      access(1'b0, a, dcache_pkg::SIZE_WORD, '0);
      access(1'b1, a, dcache_pkg::store_size_t'(2'(i)), 32'($random(seed)));
      access(1'b0, a, dcache_pkg::SIZE_WORD, '0);
      a = make_addr(4 + rnd(4), 64 + i);  // other tag, write-allocate
      access(1'b1, a, dcache_pkg::store_size_t'(2'(i)), 32'($random(seed)));
      access(1'b0, a, dcache_pkg::SIZE_WORD, '0);
    end
    test_num = 4;  // six tags fight over set 128
    for (int i = 0; i < 60; i++)
      access(1'(rnd(2)), make_addr(256 + rnd(6), 128), dcache_pkg::store_size_t'(2'(rnd(4))),
             32'($random(seed)));
    test_num = 5;
    for (int i = 0; i < 2000; i++)
      access(1'(rnd(2)), make_addr(rnd(8), rnd(64)), dcache_pkg::store_size_t'(2'(rnd(4))),
             32'($random(seed)));
    test_num = 0;  // closes the last test line
    repeat (2) @(posedge CLK);
    $display("total: %0d checks, %0d mismatches, %0d timeouts", checks, errors, 32'(hung));
    if (hung || errors != 0)
      $display("Errors found");
    else
      $display("No errors");
    $finish;
  end

endmodule

// File: list.f
source/dcache_pkg.sv
source/dcache_decode.sv
source/dcache_tag_lru.sv
source/dcache_data_store.sv
source/dcache_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_dcache.sv

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f list.f -o tb_dcache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_dcache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "No errors"; then
  exit 0
fi
exit 1
